/* src/l2sw_pkg.sv */
package l2sw_pkg;

	// Switch port count. The shared types below are sized from it.
	localparam int NUM_PORTS = 4;

	// One-byte station address.
	typedef logic [7:0] station_t;

	// Always flooded and never learned.
	localparam station_t BROADCAST_ADDR = 8'hFF;

	typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t;

	// One bit per port.
	typedef logic [NUM_PORTS-1:0] port_mask_t;

	// Input beat.
	typedef struct packed {
		logic       tvalid;
		logic [7:0] tdata;
	} axis_in_t;

	// Output beat.
	typedef struct packed {
		logic       tvalid;
		logic [7:0] tdata;
		logic       tlast;
	} axis_out_t;

	// Station table result.
	typedef struct packed {
		logic      hit;
		port_idx_t port;
	} lookup_t;

	typedef enum logic [1:0] {
		FWD_UNICAST,
		FWD_FLOOD,
		FWD_DROP
	} fwd_mode_e;

	// Core run sequence.
	typedef enum logic [2:0] {
		RUN_IDLE,
		RUN_SCAN,
		RUN_CAPTURE,
		RUN_FORWARD,
		RUN_DONE
	} run_state_e;

endpackage

/* src/egress_forward.sv */
`timescale 1ns/100ps

module egress_forward #(
	parameter int FRAME_LEN = 8
) (
	input  logic                          aclk,
	input  logic                          aresetn,
	input  logic                          start,
	input  l2sw_pkg::lookup_t             lookup,
	input  l2sw_pkg::station_t            dst_addr,
	input  l2sw_pkg::port_idx_t           src_port,
	output logic [$clog2(FRAME_LEN)-1:0]  rd_index,
	input  logic [7:0]                    rd_data,
	input  l2sw_pkg::port_mask_t          out_full_n,
	output l2sw_pkg::port_mask_t          out_write,
	output logic [7:0]                    out_din,
	output logic                          finish
);

	localparam int IDX_W = $clog2(FRAME_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_LEN - 1);

	l2sw_pkg::fwd_mode_e  mode_d;
	l2sw_pkg::fwd_mode_e  mode_q;
	l2sw_pkg::port_mask_t target_d;
	l2sw_pkg::port_mask_t target_q;
	l2sw_pkg::port_mask_t src_mask;
	logic                 busy;
	logic                 all_ready;
	logic                 send;
	logic [IDX_W-1:0]     count;

	assign src_mask = l2sw_pkg::port_mask_t'(1) << src_port;

	always_comb
	begin
		if ((dst_addr == l2sw_pkg::BROADCAST_ADDR) || !lookup.hit)
		begin
			mode_d   = l2sw_pkg::FWD_FLOOD;
			target_d = ~src_mask;
		end
		else if (lookup.port != src_port)
		begin
			mode_d   = l2sw_pkg::FWD_UNICAST;
			target_d = l2sw_pkg::port_mask_t'(1) << lookup.port;
		end
		else
		begin
			// Station sits on the port the frame came from.
			mode_d   = l2sw_pkg::FWD_DROP;
			target_d = '0;
		end
	end

	// All targets take the same beat in the same cycle.
	assign all_ready = &(out_full_n | ~target_q);
	assign send      = busy && (mode_q != l2sw_pkg::FWD_DROP) && all_ready;
	assign out_write = send ? target_q : '0;
	assign out_din   = rd_data;
	assign rd_index  = count;
	assign finish    = busy && ((mode_q == l2sw_pkg::FWD_DROP) ||
	                            (send && (count == LAST_IDX)));

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			busy     <= 1'b0;
			count    <= '0;
			mode_q   <= l2sw_pkg::FWD_DROP;
			target_q <= '0;
		end
		else if (start)
		begin
			busy     <= 1'b1;
			count    <= '0;
			mode_q   <= mode_d;
			target_q <= target_d;
		end
		else if (finish)
			busy <= 1'b0;
		else if (send)
			count <= count + 1'b1;
	end

	// Never reflect a frame back to its ingress port.
	a_no_reflect: assert property (
		@(posedge aclk) disable iff (!aresetn)
		(out_write & src_mask) == '0
	);

endmodule

/* src/ingress_capture.sv */
`timescale 1ns/100ps

module ingress_capture #(
	parameter int FRAME_LEN = 8
) (
	input  logic                          aclk,
	input  logic                          aresetn,
	input  logic                          start,
	input  logic [7:0]                    in_dout [l2sw_pkg::NUM_PORTS],
	input  l2sw_pkg::port_mask_t          in_empty_n,
	output l2sw_pkg::port_mask_t          in_read,
	output l2sw_pkg::port_idx_t           src_port,
	output logic                          byte_strobe,
	output logic [$clog2(FRAME_LEN)-1:0]  byte_index,
	output l2sw_pkg::station_t            byte_data,
	output logic                          capture_done,
	input  logic [$clog2(FRAME_LEN)-1:0]  rd_index,
	output logic [7:0]                    rd_data
);

	localparam int IDX_W = $clog2(FRAME_LEN);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_LEN - 1);

	logic                scanning;
	logic                capturing;
	l2sw_pkg::port_idx_t next_ptr;
	logic                scan_hit;
	l2sw_pkg::port_idx_t scan_pick;
	logic [IDX_W-1:0]    count;
	logic [7:0]          frame_buf [FRAME_LEN];

	// Round robin from next_ptr. Walked backwards so the nearest port wins.
	always_comb
	begin
		scan_hit  = 1'b0;
		scan_pick = next_ptr;
		for (int i = l2sw_pkg::NUM_PORTS - 1; i >= 0; i--)
		begin
			if (in_empty_n[next_ptr + l2sw_pkg::port_idx_t'(i)])
			begin
				scan_hit  = 1'b1;
				scan_pick = next_ptr + l2sw_pkg::port_idx_t'(i);
			end
		end
	end

	assign in_read      = capturing ?
	                      ((l2sw_pkg::port_mask_t'(1) << src_port) & in_empty_n) : '0;
	assign byte_strobe  = |in_read;
	assign byte_index   = count;
	assign byte_data    = in_dout[src_port];
	assign capture_done = byte_strobe && (count == LAST_IDX);
	assign rd_data      = frame_buf[rd_index];

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			scanning  <= 1'b0;
			capturing <= 1'b0;
			next_ptr  <= '0;
			src_port  <= '0;
			count     <= '0;
		end
		else
		begin
			if (start)
				scanning <= 1'b1;
			if (scanning && scan_hit)
			begin
				scanning  <= 1'b0;
				capturing <= 1'b1;
				src_port  <= scan_pick;
				next_ptr  <= scan_pick + 1'b1;
				count     <= '0;
			end
			if (byte_strobe)
			begin
				count <= count + 1'b1;
				if (count == LAST_IDX)
					capturing <= 1'b0;
			end
		end
	end

	always_ff @(posedge aclk)
	begin
		if (byte_strobe)
			frame_buf[count] <= byte_data;
	end

	// A new run never starts while a frame is still coming in.
	a_start_when_free: assert property (
		@(posedge aclk) disable iff (!aresetn)
		start |-> !scanning && !capturing
	);

endmodule

/* src/mac_table.sv */
`timescale 1ns/100ps

module mac_table #(
	parameter int FRAME_LEN   = 8,
	parameter int TABLE_DEPTH = 16
) (
	input  logic                          aclk,
	input  logic                          aresetn,
	input  logic                          byte_strobe,
	input  logic [$clog2(FRAME_LEN)-1:0]  byte_index,
	input  l2sw_pkg::station_t            byte_data,
	input  l2sw_pkg::port_idx_t           src_port,
	output l2sw_pkg::lookup_t             lookup,
	output l2sw_pkg::station_t            dst_addr
);

	localparam int IDX_W  = $clog2(FRAME_LEN);
	localparam int ADDR_W = $clog2(TABLE_DEPTH);

	logic [TABLE_DEPTH-1:0] entry_valid;
	l2sw_pkg::station_t     entry_tag [TABLE_DEPTH];
	l2sw_pkg::port_idx_t    entry_port [TABLE_DEPTH];
	logic [ADDR_W-1:0]      slot;
	logic                   is_dst;
	logic                   learn;

	// Direct mapped on the low address bits.
	assign slot   = byte_data[ADDR_W-1:0];
	assign is_dst = byte_strobe && (byte_index == '0);
	assign learn  = byte_strobe && (byte_index == IDX_W'(1)) &&
	                (byte_data != l2sw_pkg::BROADCAST_ADDR);

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			entry_valid <= '0;
			lookup      <= '0;
		end
		else
		begin
			// Byte 0 lookup sees the table before this frame's learn.
			if (is_dst)
			begin
				lookup.hit  <= entry_valid[slot] && (entry_tag[slot] == byte_data);
				lookup.port <= entry_port[slot];
			end
			if (learn)
				entry_valid[slot] <= 1'b1;
		end
	end

	always_ff @(posedge aclk)
	begin
		if (is_dst)
			dst_addr <= byte_data;
		// Collisions simply overwrite.
		if (learn)
		begin
			entry_tag[slot]  <= byte_data;
			entry_port[slot] <= src_port;
		end
	end

endmodule

/* src/layer2_switch.sv */
`timescale 1ns/100ps

module layer2_switch #(
	parameter int FRAME_LEN   = 8,
	parameter int TABLE_DEPTH = 16
) (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 ap_start,
	output logic                 ap_done,
	output logic                 ap_idle,
	input  logic [7:0]           in_dout [l2sw_pkg::NUM_PORTS],
	input  l2sw_pkg::port_mask_t in_empty_n,
	output l2sw_pkg::port_mask_t in_read,
	output logic [7:0]           out_din,
	input  l2sw_pkg::port_mask_t out_full_n,
	output l2sw_pkg::port_mask_t out_write
);

	localparam int IDX_W = $clog2(FRAME_LEN);

	l2sw_pkg::run_state_e state;
	logic                 run_start;
	l2sw_pkg::port_idx_t  src_port;
	logic                 byte_strobe;
	logic [IDX_W-1:0]     byte_index;
	l2sw_pkg::station_t   byte_data;
	logic                 capture_done;
	logic [IDX_W-1:0]     rd_index;
	logic [7:0]           rd_data;
	l2sw_pkg::lookup_t    lookup;
	l2sw_pkg::station_t   dst_addr;
	logic                 fwd_finish;

	// The cycle after done already counts as idle.
	assign ap_idle   = (state == l2sw_pkg::RUN_IDLE) || (state == l2sw_pkg::RUN_DONE);
	assign run_start = ap_start && ap_idle;
	assign ap_done   = (state == l2sw_pkg::RUN_FORWARD) && fwd_finish;

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
			state <= l2sw_pkg::RUN_IDLE;
		else
		begin
			case (state)
				l2sw_pkg::RUN_IDLE,
				l2sw_pkg::RUN_DONE:
					state <= run_start ? l2sw_pkg::RUN_SCAN : l2sw_pkg::RUN_IDLE;
				l2sw_pkg::RUN_SCAN:
					if (|in_read)
						state <= l2sw_pkg::RUN_CAPTURE;
				l2sw_pkg::RUN_CAPTURE:
					if (capture_done)
						state <= l2sw_pkg::RUN_FORWARD;
				l2sw_pkg::RUN_FORWARD:
					if (fwd_finish)
						state <= l2sw_pkg::RUN_DONE;
				default:
					state <= l2sw_pkg::RUN_IDLE;
			endcase
		end
	end

	ingress_capture #(.FRAME_LEN(FRAME_LEN)) u_ingress (
		.aclk (aclk), .aresetn (aresetn), .start (run_start),
		.in_dout (in_dout), .in_empty_n (in_empty_n), .in_read (in_read),
		.src_port (src_port), .byte_strobe (byte_strobe), .byte_index (byte_index),
		.byte_data (byte_data), .capture_done (capture_done),
		.rd_index (rd_index), .rd_data (rd_data)
	);

	mac_table #(.FRAME_LEN(FRAME_LEN), .TABLE_DEPTH(TABLE_DEPTH)) u_table (
		.aclk (aclk), .aresetn (aresetn), .byte_strobe (byte_strobe),
		.byte_index (byte_index), .byte_data (byte_data), .src_port (src_port),
		.lookup (lookup), .dst_addr (dst_addr)
	);

	egress_forward #(.FRAME_LEN(FRAME_LEN)) u_egress (
		.aclk (aclk), .aresetn (aresetn), .start (capture_done),
		.lookup (lookup), .dst_addr (dst_addr), .src_port (src_port),
		.rd_index (rd_index), .rd_data (rd_data), .out_full_n (out_full_n),
		.out_write (out_write), .out_din (out_din), .finish (fwd_finish)
	);

	// Store and forward, so reads and writes never overlap.
	a_no_cut_through: assert property (
		@(posedge aclk) disable iff (!aresetn)
		!((|in_read) && (|out_write))
	);

endmodule

/* src/layer2_switch_axi.sv */
`timescale 1ns/100ps

module layer2_switch_axi #(
	parameter int FRAME_LEN   = 8,
	parameter int TABLE_DEPTH = 16
) (
	input  logic                  aclk,
	input  logic                  aresetn,
	input  l2sw_pkg::axis_in_t    packet_in [l2sw_pkg::NUM_PORTS],
	output l2sw_pkg::port_mask_t  packet_in_tready,
	output l2sw_pkg::axis_out_t   packet_out [l2sw_pkg::NUM_PORTS],
	input  l2sw_pkg::port_mask_t  packet_out_tready
);

	logic                 ap_start_r;
	logic                 start_count;
	logic                 start_count_clr;
	logic                 ap_done;
	logic                 ap_idle;
	logic [7:0]           in_dout [l2sw_pkg::NUM_PORTS];
	l2sw_pkg::port_mask_t in_empty_n;
	l2sw_pkg::port_mask_t out_write;
	logic [7:0]           out_din;

	// The flag drops on the done cycle, which relaunches the next run.
	assign start_count_clr = start_count && !ap_done;

	always_ff @(posedge aclk)
	begin
		if (!aresetn)
		begin
			ap_start_r  <= 1'b0;
			start_count <= 1'b0;
		end
		else
		begin
			ap_start_r  <= !start_count_clr;
			start_count <= 1'b1;
		end
	end

	// FIFO strobes onto the stream ports.
	for (genvar i = 0; i < l2sw_pkg::NUM_PORTS; i++)
	begin : g_port
		assign in_dout[i]           = packet_in[i].tdata;
		assign in_empty_n[i]        = packet_in[i].tvalid;
		assign packet_out[i].tvalid = out_write[i];
		assign packet_out[i].tdata  = out_din;
		assign packet_out[i].tlast  = ap_done;
	end

	layer2_switch #(
		.FRAME_LEN   (FRAME_LEN),
		.TABLE_DEPTH (TABLE_DEPTH)
	) u_core (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.ap_start   (ap_start_r),
		.ap_done    (ap_done),
		.ap_idle    (ap_idle),
		.in_dout    (in_dout),
		.in_empty_n (in_empty_n),
		.in_read    (packet_in_tready),
		.out_din    (out_din),
		.out_full_n (packet_out_tready),
		.out_write  (out_write)
	);

	// A new run is only launched into an idle core.
	a_start_when_idle: assert property (
		@(posedge aclk) disable iff (!aresetn)
		$rose(ap_start_r) |-> ap_idle
	);

endmodule

/* dv/l2sw_frame_table.svh */
`ifndef L2SW_FRAME_TABLE_SVH
`define L2SW_FRAME_TABLE_SVH

// Columns: input port, destination, source, payload seed, expected output ports,
// offered together with the next row, random output back-pressure.
typedef struct packed {
	l2sw_pkg::port_idx_t  port;
	l2sw_pkg::station_t   dst;
	l2sw_pkg::station_t   src;
	logic [7:0]           seed;
	l2sw_pkg::port_mask_t exp_mask;
	logic                 paired;
	logic                 backpressure;
} frame_row_t;

localparam int NUM_ROWS = 18;

// Masks follow the forwarding rules and the table state left by the rows above.
localparam frame_row_t FRAME_TABLE [NUM_ROWS] = '{
	'{2'd0, 8'h22, 8'h11, 8'h30, 4'b1110, 1'b0, 1'b0},
	'{2'd2, 8'h11, 8'h33, 8'h41, 4'b0001, 1'b0, 1'b0},
	'{2'd1, 8'h33, 8'h22, 8'h52, 4'b0100, 1'b0, 1'b0},
	// Station 11 lives on port 0 itself.
	'{2'd0, 8'h11, 8'h66, 8'h63, 4'b0000, 1'b0, 1'b0},
	'{2'd3, 8'h66, 8'h44, 8'h74, 4'b0001, 1'b0, 1'b0},
	'{2'd1, 8'hFF, 8'h0F, 8'h85, 4'b1101, 1'b0, 1'b0},
	'{2'd2, 8'h77, 8'hFF, 8'h96, 4'b1011, 1'b0, 1'b0},
	// Station 0F still holds slot F after the broadcast source.
	'{2'd0, 8'h0F, 8'h99, 8'hA7, 4'b0010, 1'b0, 1'b0},
	// Pairs. Masks assume the round-robin order, port 3 then port 0.
	'{2'd0, 8'h44, 8'hAA, 8'hB8, 4'b1000, 1'b1, 1'b0},
	'{2'd3, 8'hAA, 8'h55, 8'hC9, 4'b0111, 1'b0, 1'b0},
	// Port 1 then port 2.
	'{2'd2, 8'h55, 8'hBB, 8'hDA, 4'b1000, 1'b1, 1'b0},
	'{2'd1, 8'hBB, 8'hCC, 8'hEB, 4'b1101, 1'b0, 1'b0},
	'{2'd0, 8'hCC, 8'h11, 8'h0C, 4'b0010, 1'b0, 1'b1},
	'{2'd3, 8'hDD, 8'h44, 8'h1D, 4'b0111, 1'b0, 1'b1},
	'{2'd1, 8'hFF, 8'h22, 8'h2E, 4'b1101, 1'b0, 1'b1},
	'{2'd2, 8'h22, 8'h33, 8'h3F, 4'b0010, 1'b0, 1'b1},
	// Station 21 evicts station 11 from slot 1.
	'{2'd1, 8'hEE, 8'h21, 8'h40, 4'b1101, 1'b0, 1'b1},
	'{2'd2, 8'h11, 8'h33, 8'h51, 4'b1011, 1'b0, 1'b1}
};

`endif

/* dv/tb_layer2_switch_axi.sv */
`timescale 1ns/100ps

module tb_layer2_switch_axi;

	localparam int FRAME_LEN      = 8;
	localparam int TABLE_DEPTH    = 16;
	localparam int NUM_PORTS      = l2sw_pkg::NUM_PORTS;
	localparam int TIMEOUT_CYCLES = 2000;

	`include "l2sw_frame_table.svh"

	logic                 aclk;
	logic                 aresetn;
	l2sw_pkg::axis_in_t   packet_in [NUM_PORTS] = '{default: '0};
	l2sw_pkg::port_mask_t packet_in_tready;
	l2sw_pkg::axis_out_t  packet_out [NUM_PORTS];
	l2sw_pkg::port_mask_t packet_out_tready = '1;

	logic [7:0]          tx_bytes [NUM_PORTS][$];
	l2sw_pkg::axis_out_t rx_beats [NUM_PORTS][$];
	int                  valid_cycles [NUM_PORTS] = '{default: 0};
	int                  valid_mark [NUM_PORTS] = '{default: 0};
	int                  done_count = 0;
	int                  expected_done = 0;
	logic                bp_on = 1'b0;
	logic [31:0]         lfsr_state = 32'h2e34;
	l2sw_pkg::port_idx_t next_port = '0;
	int                  value_errors = 0;
	int                  frame_errors = 0;
	int                  timeouts = 0;

	layer2_switch_axi #(
		.FRAME_LEN   (FRAME_LEN),
		.TABLE_DEPTH (TABLE_DEPTH)
	) u_dut (
		.aclk              (aclk),
		.aresetn           (aresetn),
		.packet_in         (packet_in),
		.packet_in_tready  (packet_in_tready),
		.packet_out        (packet_out),
		.packet_out_tready (packet_out_tready)
	);

	initial
	begin
		aclk = 1'b0;
		forever
			#4 aclk = ~aclk;
	end

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	// Payload mixes the seed with the byte position.
	function automatic logic [7:0] frame_byte(input int row, input int i);
		if (i == 0)
			return FRAME_TABLE[row].dst;
		if (i == 1)
			return FRAME_TABLE[row].src;
		return FRAME_TABLE[row].seed ^ 8'(i * 37);
	endfunction

	// Nearest port at or after next_port wins.
	function automatic logic served_before(input l2sw_pkg::port_idx_t a,
		input l2sw_pkg::port_idx_t b);
		l2sw_pkg::port_idx_t dist_a;
		l2sw_pkg::port_idx_t dist_b;
		dist_a = a - next_port;
		dist_b = b - next_port;
		return dist_a < dist_b;
	endfunction

	task automatic check_beat(input string name, input l2sw_pkg::axis_out_t got,
		input l2sw_pkg::axis_out_t exp);
		if (got.tvalid !== exp.tvalid)
		begin
			$display("Error %s tvalid: got %h expected %h", name, got.tvalid, exp.tvalid);
			value_errors++;
		end
		if (got.tdata !== exp.tdata)
		begin
			$display("Error %s tdata: got %h expected %h", name, got.tdata, exp.tdata);
			value_errors++;
		end
		if (got.tlast !== exp.tlast)
		begin
			$display("Error %s tlast: got %h expected %h", name, got.tlast, exp.tlast);
			value_errors++;
		end
	endtask

	task automatic check_mask(input string name, input l2sw_pkg::port_mask_t got,
		input l2sw_pkg::port_mask_t exp);
		if (got !== exp)
		begin
			$display("Error %s: got %h expected %h", name, got, exp);
			value_errors++;
		end
	endtask

	task automatic queue_frame(input int row);
		for (int i = 0; i < FRAME_LEN; i++)
			tx_bytes[FRAME_TABLE[row].port].push_back(frame_byte(row, i));
	endtask

	task automatic run_frame(input int row, output logic ok);
		int                   cycles;
		l2sw_pkg::port_mask_t seen;
		l2sw_pkg::axis_out_t  exp_beat;
		cycles = 0;
		ok = 1'b1;
		seen = '0;
		expected_done++;
		while (ok && done_count < expected_done)
		begin
			@(negedge aclk);
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("Timeout: the frame of row %0d never finished", row);
				timeouts++;
				ok = 1'b0;
			end
		end
		if (ok)
		begin
			for (int p = 0; p < NUM_PORTS; p++)
			begin
				seen[p] = (valid_cycles[p] != valid_mark[p]);
				valid_mark[p] = valid_cycles[p];
				if (FRAME_TABLE[row].exp_mask[p])
				begin
					if (rx_beats[p].size() != FRAME_LEN)
					begin
						$display("Row %0d: port %0d delivered %0d bytes instead of %0d",
							row, p, rx_beats[p].size(), FRAME_LEN);
						frame_errors++;
					end
					for (int i = 0; i < rx_beats[p].size() && i < FRAME_LEN; i++)
					begin
						exp_beat.tvalid = 1'b1;
						exp_beat.tdata  = frame_byte(row, i);
						exp_beat.tlast  = (i == FRAME_LEN - 1);
						check_beat($sformatf("packet_out[%0d] byte %0d of row %0d", p, i, row),
							rx_beats[p][i], exp_beat);
					end
				end
				rx_beats[p].delete();
			end
			check_mask($sformatf("packet_out tvalid ports of row %0d", row), seen,
				FRAME_TABLE[row].exp_mask);
			next_port = FRAME_TABLE[row].port + 1'b1;
		end
	endtask

	// Inputs show the head of each port queue. Ready comes from the LFSR under back-pressure.
	always @(posedge aclk)
	begin : drive_ports
		l2sw_pkg::port_mask_t ready_bits;
		ready_bits = '1;
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (packet_in[p].tvalid && packet_in_tready[p])
				void'(tx_bytes[p].pop_front());
			if (tx_bytes[p].size() > 0)
				packet_in[p] <= '{tvalid: 1'b1, tdata: tx_bytes[p][0]};
			else
				packet_in[p] <= '0;
			if (bp_on)
			begin
				lfsr_state = lfsr_next(lfsr_state);
				ready_bits[p] = lfsr_state[0];
			end
		end
		packet_out_tready <= ready_bits;
	end

	always @(posedge aclk)
	begin : watch_ports
		// Only the captured port may take a byte.
		if (aresetn && !$onehot0(packet_in_tready))
		begin
			$display("More than one input port was ready in the same cycle");
			frame_errors++;
		end
		for (int p = 0; p < NUM_PORTS; p++)
		begin
			if (packet_out[p].tvalid)
				valid_cycles[p]++;
			// Done cycles are kept too, so a tlast without a byte shows up.
			if ((packet_out[p].tvalid && packet_out_tready[p]) || packet_out[p].tlast)
				rx_beats[p].push_back(packet_out[p]);
		end
		// Every tlast carries the run done pulse.
		if (packet_out[0].tlast)
			done_count++;
	end

	initial
	begin : main_seq
		int   row;
		int   first;
		logic ok;
		aresetn = 1'b0;
		repeat (5)
			@(posedge aclk);
		aresetn <= 1'b1;
		row = 0;
		ok = 1'b1;
		while (ok && row < NUM_ROWS)
		begin
			@(negedge aclk);
			bp_on = FRAME_TABLE[row].backpressure;
			queue_frame(row);
			if (FRAME_TABLE[row].paired)
			begin
				queue_frame(row + 1);
				first = served_before(FRAME_TABLE[row].port, FRAME_TABLE[row + 1].port) ?
					row : row + 1;
				run_frame(first, ok);
				if (ok)
					run_frame((first == row) ? row + 1 : row, ok);
				row += 2;
			end
			else
			begin
				run_frame(row, ok);
				row++;
			end
		end
		$display("Summary: %0d value errors, %0d frame errors, %0d timeouts",
			value_errors, frame_errors, timeouts);
		if (value_errors == 0 && frame_errors == 0 && timeouts == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

/* layer2_switch_axi.f */
+incdir+dv
src/l2sw_pkg.sv
src/egress_forward.sv
src/ingress_capture.sv
src/mac_table.sv
src/layer2_switch.sv
src/layer2_switch_axi.sv
dv/tb_layer2_switch_axi.sv

/* Makefile */
TOP := tb_layer2_switch_axi

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --top-module layer2_switch_axi \
		src/l2sw_pkg.sv src/egress_forward.sv src/ingress_capture.sv \
		src/mac_table.sv src/layer2_switch.sv src/layer2_switch_axi.sv

sim:
	verilator --binary --timing --assert -f layer2_switch_axi.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
